// File: Makefile
# Verilator build and run of the PLL controller testbench.

TOP       ?= tb_pll_ctrl
FILELIST  ?= pll_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: clk_div_chain.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module clk_div_chain (
  input  logic CLKS,
  input  logic RSTXS,
  output logic clkf_data,
  output logic slow_tick
);

  // bit 0 is the divide-by-two, every higher bit halves the one below.
  logic [`DIV_STAGES:0] div_q;
  logic [`DIV_STAGES:0] div_d1;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      div_q  <= '0;
      div_d1 <= '0;
    end else begin
      div_d1   <= div_q;
      div_q[0] <= ~div_q[0];
      for (int i = 1; i <= `DIV_STAGES; i++) begin
        if (div_q[i-1] && !div_d1[i-1]) begin
          div_q[i] <= ~div_q[i]; // toggle on the rising edge of the stage below.
        end
      end
    end
  end

  assign clkf_data = div_q[`DIV_STAGES];

  // high in the first cycle of the high half of clkf_data.
  assign slow_tick = div_q[`DIV_STAGES] && !div_d1[`DIV_STAGES];

endmodule

// File: pll_cfg_rom.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module pll_cfg_rom import pll_drp_pkg::*, pll_ctrl_pkg::*; (
  input  logic [`CFG_SEL_W-1:0]  sel,
  input  logic [`DRP_ADDR_W-1:0] addr,
  input  drp_word_u              old_word,
  output drp_word_u              new_word
);

  pll_cfg_t   cfg;
  logic       is_fb;
  logic       is_reg1;
  logic [7:0] n_val;
  logic [7:0] high_n;
  logic [7:0] low_n;

  always_comb begin
    case (sel)
      2'd0: cfg = '{fb_mult: 8'd32, out0_div: 8'd2};
      2'd1: cfg = '{fb_mult: 8'd16, out0_div: 8'd1};
      2'd2: cfg = '{fb_mult: 8'd24, out0_div: 8'd3};
      default: cfg = '{fb_mult: 8'd20, out0_div: 8'd5};
    endcase
  end

  assign is_fb   = (addr == `DRP_ADDR_FB1) || (addr == `DRP_ADDR_FB2);
  assign is_reg1 = (addr == `DRP_ADDR_FB1) || (addr == `DRP_ADDR_OUT1);

  assign n_val  = is_fb ? cfg.fb_mult : cfg.out0_div;
  assign high_n = n_val >> 1;
  assign low_n  = n_val - high_n; // odd values put the extra cycle in the low time.

  // bits that the divider does not own pass through from the read word.
  always_comb begin
    new_word = old_word;
    if (is_reg1) begin
      new_word.r1.high_time = high_n[5:0];
      new_word.r1.low_time  = low_n[5:0];
    end else begin
      new_word.r2.edge_bit = n_val[0];
      new_word.r2.no_count = (n_val == 8'd1);
    end
  end

endmodule

// File: pll_ctrl.f
+incdir+.
pll_drp_pkg.sv
pll_ctrl_pkg.sv
pll_cfg_rom.sv
pll_drp_seq.sv
clk_div_chain.sv
reset_release.sv
pll_ctrl_top.sv
tb_pll_ctrl.sv

// File: pll_ctrl_defines.svh
`ifndef PLL_CTRL_DEFINES_SVH
`define PLL_CTRL_DEFINES_SVH

// DRP port sizes.
`define DRP_ADDR_W 5
`define DRP_DATA_W 16
`define CFG_SEL_W 2

// feedback divider register pair.
`define DRP_ADDR_FB1 5'h14
`define DRP_ADDR_FB2 5'h15

// output 0 divider register pair.
`define DRP_ADDR_OUT1 5'h08
`define DRP_ADDR_OUT2 5'h09

`define POR_STRETCH 15 // cycles of power-on stretch.
`define POR_CNT_W 4
`define LOCK_SYNC_W 2

// toggle stages behind the free running divide-by-two.
`define DIV_STAGES 4

`endif

// File: pll_ctrl_pkg.sv
package pll_ctrl_pkg;

  // one entry of the configuration table.
  typedef struct packed {
    logic [7:0] fb_mult;
    logic [7:0] out0_div;
  } pll_cfg_t;

  // released resets, both active low.
  typedef struct packed {
    logic rstx_fast;
    logic rstx_slow;
  } rst_out_t;

endpackage

// File: pll_ctrl_top.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module pll_ctrl_top import pll_drp_pkg::*, pll_ctrl_pkg::*; (
  input  logic                   CLKS,
  input  logic                   RSTXS,
  input  logic [`CFG_SEL_W-1:0]  cfg_sel,
  input  logic                   cfg_chg,
  output drp_req_t               drp_req,
  input  logic [`DRP_DATA_W-1:0] drp_do,
  input  logic                   drp_rdy,
  input  logic                   pll_locked,
  output logic                   pll_rst,
  output logic                   cfg_busy,
  output logic                   clkf_data,
  output logic                   slow_tick,
  output rst_out_t               rst_out
);

  pll_drp_seq u_drp_seq (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .cfg_sel    (cfg_sel),
    .cfg_chg    (cfg_chg),
    .drp_req    (drp_req),
    .drp_do     (drp_do),
    .drp_rdy    (drp_rdy),
    .pll_locked (pll_locked),
    .pll_rst    (pll_rst),
    .cfg_busy   (cfg_busy)
  );

  clk_div_chain u_clk_div (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .clkf_data (clkf_data),
    .slow_tick (slow_tick)
  );

  // busy from the sequencer holds both domains in reset.
  reset_release u_rst_rel (
    .CLKS      (CLKS),
    .RSTXS     (RSTXS),
    .cfg_busy  (cfg_busy),
    .slow_tick (slow_tick),
    .rst_out   (rst_out)
  );

endmodule

// File: pll_drp_pkg.sv
`include "pll_ctrl_defines.svh"

package pll_drp_pkg;

  // one request on the DRP port.
  typedef struct packed {
    logic                   den;
    logic                   dwe;
    logic [`DRP_ADDR_W-1:0] daddr;
    logic [`DRP_DATA_W-1:0] di;
  } drp_req_t;

  // first register of a divider pair.
  typedef struct packed {
    logic [2:0] phase_mux;
    logic       rsvd;
    logic [5:0] high_time;
    logic [5:0] low_time;
  } clkreg1_t;

  // second register of a divider pair.
  typedef struct packed {
    logic [7:0] rsvd;
    logic       edge_bit;   // odd divide, adds half a cycle to the high time.
    logic       no_count;   // divide by one bypasses the counter.
    logic [5:0] delay_time;
  } clkreg2_t;

  // the address tells which view of the word is valid.
  typedef union packed {
    clkreg1_t r1;
    clkreg2_t r2;
  } drp_word_u;

endpackage

// File: pll_drp_seq.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module pll_drp_seq import pll_drp_pkg::*; (
  input  logic                   CLKS,
  input  logic                   RSTXS,
  input  logic [`CFG_SEL_W-1:0]  cfg_sel,
  input  logic                   cfg_chg,
  output drp_req_t               drp_req,
  input  logic [`DRP_DATA_W-1:0] drp_do,
  input  logic                   drp_rdy,
  input  logic                   pll_locked,
  output logic                   pll_rst,
  output logic                   cfg_busy
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RD,
    S_RD_WAIT,
    S_WR,
    S_WR_WAIT,
    S_LOCK
  } state_t;

  state_t                  state;
  logic [1:0]              step;      // which of the four registers is in work.
  logic [`CFG_SEL_W-1:0]   sel_q;
  logic [`DRP_ADDR_W-1:0]  addr;
  logic [`LOCK_SYNC_W-1:0] lock_sync;
  drp_word_u               rd_word;
  drp_word_u               wr_word;

  pll_cfg_rom u_rom (
    .sel      (sel_q),
    .addr     (addr),
    .old_word (rd_word),
    .new_word (wr_word)
  );

  always_comb begin
    case (step)
      2'd0: addr = `DRP_ADDR_FB1;
      2'd1: addr = `DRP_ADDR_FB2;
      2'd2: addr = `DRP_ADDR_OUT1;
      default: addr = `DRP_ADDR_OUT2;
    endcase
  end

  assign drp_req.den   = (state == S_RD) || (state == S_WR);
  assign drp_req.dwe   = (state == S_WR);
  assign drp_req.daddr = addr;
  assign drp_req.di    = wr_word;

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      lock_sync <= '0;
    end else begin
      lock_sync <= {lock_sync[`LOCK_SYNC_W-2:0], pll_locked};
    end
  end

  always_ff @(posedge CLKS) begin
    if (state == S_RD_WAIT && drp_rdy) begin
      rd_word <= drp_do;
    end
  end

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      state    <= S_IDLE;
      step     <= 2'd0;
      sel_q    <= '0;
      pll_rst  <= 1'b1;
      cfg_busy <= 1'b1; // set 0 is loaded right after reset.
    end else begin
      case (state)
        S_IDLE: begin
          if (cfg_busy) begin
            state <= S_RD;
          end else if (cfg_chg) begin
            sel_q    <= cfg_sel;
            pll_rst  <= 1'b1;
            cfg_busy <= 1'b1;
            state    <= S_RD;
          end
        end
        S_RD: state <= S_RD_WAIT;
        S_RD_WAIT: begin
          if (drp_rdy) begin
            state <= S_WR;
          end
        end
        S_WR: state <= S_WR_WAIT;
        S_WR_WAIT: begin
          if (drp_rdy) begin
            step <= step + 2'd1; // wraps back to FB1 after the last pair.
            if (step == 2'd3) begin
              pll_rst <= 1'b0;
              state   <= S_LOCK;
            end else begin
              state <= S_RD;
            end
          end
        end
        S_LOCK: begin
          if (lock_sync[`LOCK_SYNC_W-1]) begin
            cfg_busy <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: reset_release.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module reset_release import pll_ctrl_pkg::*; (
  input  logic     CLKS,
  input  logic     RSTXS,
  input  logic     cfg_busy,
  input  logic     slow_tick,
  output rst_out_t rst_out
);

  logic [`POR_CNT_W-1:0] por_cnt;
  logic                  por_done;
  logic                  rel_ok;
  logic                  fast_pre;
  logic                  fast_next;

  assign por_done  = (por_cnt == '0);
  assign rel_ok    = por_done && !cfg_busy;
  assign fast_next = fast_pre && rel_ok; // a busy PLL pulls the reset at once.

  always_ff @(posedge CLKS or negedge RSTXS) begin
    if (!RSTXS) begin
      por_cnt  <= `POR_CNT_W'(`POR_STRETCH);
      fast_pre <= 1'b0;
      rst_out  <= '0;
    end else begin
      if (!por_done) begin
        por_cnt <= por_cnt - `POR_CNT_W'(1);
      end
      fast_pre          <= rel_ok;
      rst_out.rstx_fast <= fast_next;

      // the slow domain follows on its first tick once the fast domain runs.
      rst_out.rstx_slow <= fast_next &&
                           (rst_out.rstx_slow || (rst_out.rstx_fast && slow_tick));
    end
  end

endmodule

// File: tb_pll_ctrl.sv
`timescale 1ns/1ps
`include "pll_ctrl_defines.svh"

module tb_pll_ctrl import pll_drp_pkg::*, pll_ctrl_pkg::*;;

  logic                   CLKS = 1'b0;
  logic                   RSTXS;
  logic [`CFG_SEL_W-1:0]  cfg_sel;
  logic                   cfg_chg;
  drp_req_t               drp_req;
  logic [`DRP_DATA_W-1:0] drp_do = '0;
  logic                   drp_rdy = 1'b0;
  logic                   pll_locked = 1'b0;
  logic                   pll_rst;
  logic                   cfg_busy;
  logic                   clkf_data;
  logic                   slow_tick;
  rst_out_t               rst_out;

  // PLL model state.
  logic [`DRP_DATA_W-1:0] regfile [32];
  logic [`DRP_DATA_W-1:0] snap [32];    // register file before a sequence starts.
  logic                   filled = 1'b0;
  drp_req_t               pend;
  logic                   port_busy = 1'b0;
  logic                   rd_valid = 1'b0;
  logic [`DRP_ADDR_W-1:0] rd_addr;
  int                     rdy_cnt = 0;
  int                     lock_cnt = 0;

  // monitor state, each counter is owned by one block.
  logic busy_d = 1'b1;
  logic slow_d = 1'b0;
  logic tick_d = 1'b0;
  logic clkf_d = 1'b0;
  int   run_len = 0;
  int   runs_seen = 0;
  int   tick_gap = 0;
  int   ticks_seen = 0;
  int   port_errs = 0;
  int   den_errs = 0;
  int   rel_errs = 0;
  int   div_errs = 0;
  int   timeouts = 0;
  int   tests_passed = 0;
  int   chk_errs [1:5];

  pll_ctrl_top dut0 (
    .CLKS       (CLKS),
    .RSTXS      (RSTXS),
    .cfg_sel    (cfg_sel),
    .cfg_chg    (cfg_chg),
    .drp_req    (drp_req),
    .drp_do     (drp_do),
    .drp_rdy    (drp_rdy),
    .pll_locked (pll_locked),
    .pll_rst    (pll_rst),
    .cfg_busy   (cfg_busy),
    .clkf_data  (clkf_data),
    .slow_tick  (slow_tick),
    .rst_out    (rst_out)
  );

  always #20 CLKS = ~CLKS;

  function automatic logic [7:0] cfg_fb_mult(input logic [1:0] sel);
    case (sel)
      2'd0: return 8'd32;
      2'd1: return 8'd16;
      2'd2: return 8'd24;
      default: return 8'd20;
    endcase
  endfunction

  function automatic logic [7:0] cfg_out_div(input logic [1:0] sel);
    case (sel)
      2'd0: return 8'd2;
      2'd1: return 8'd1;
      2'd2: return 8'd3;
      default: return 8'd5;
    endcase
  endfunction

  function automatic logic is_div_addr(input logic [4:0] addr);
    return addr == `DRP_ADDR_FB1 || addr == `DRP_ADDR_FB2 ||
           addr == `DRP_ADDR_OUT1 || addr == `DRP_ADDR_OUT2;
  endfunction

  // expected register word for a divide value taken from the set.
  function automatic logic [15:0] merge_word(input logic [15:0] old, input logic [4:0] addr,
                                             input logic [1:0] sel);
    logic [7:0] n;
    logic [7:0] hi;
    logic [7:0] lo;
    n  = (addr == `DRP_ADDR_FB1 || addr == `DRP_ADDR_FB2) ? cfg_fb_mult(sel) : cfg_out_div(sel);
    hi = n / 8'd2;
    lo = n - hi;
    if (addr == `DRP_ADDR_FB1 || addr == `DRP_ADDR_OUT1) begin
      return {old[15:12], hi[5:0], lo[5:0]};
    end
    return {old[15:8], n[0], n == 8'd1, old[5:0]};
  endfunction

  function automatic int test_errs(input int id);
    case (id)
      2: return chk_errs[2] + port_errs;
      3: return chk_errs[3] + den_errs;
      4: return chk_errs[4] + rel_errs;
      5: return chk_errs[5] + div_errs;
      default: return chk_errs[1];
    endcase
  endfunction

  task automatic give_up(input string what);
    $display("timeout at %0t: no %s within the allowed cycles", $time, what);
    timeouts++;
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp, input int id);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      chk_errs[id]++;
    end
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    while (cfg_busy !== level && n < limit) begin
      @(negedge CLKS);
      n++;
    end
    if (cfg_busy !== level) begin
      give_up(level ? "rise of cfg_busy" : "fall of cfg_busy");
    end
  endtask

  task automatic take_snapshot();
    for (int a = 0; a < 32; a++) begin
      snap[a[4:0]] = regfile[a[4:0]];
    end
  endtask

  task automatic check_regs(input logic [1:0] sel, input int id);
    logic [`DRP_DATA_W-1:0] exp;
    for (int a = 0; a < 32; a++) begin
      exp = is_div_addr(a[4:0]) ? merge_word(snap[a[4:0]], a[4:0], sel) : snap[a[4:0]];
      if (regfile[a[4:0]] !== exp) begin
        $display("CHECK FAILED at %0t: regfile[%02h] got %04h expected %04h",
                 $time, a[4:0], regfile[a[4:0]], exp);
        chk_errs[id]++;
      end
    end
  endtask

  // rstx_fast is due two cycles after busy drops.
  task automatic check_fast_release();
    int n;
    n = 0;
    while (!rst_out.rstx_fast && n < 4) begin
      @(negedge CLKS);
      n++;
    end
    expect_bit("rstx_fast", rst_out.rstx_fast, 1'b1, 4);
  endtask

  task automatic pulse_chg(input logic [1:0] sel);
    cfg_sel = sel;
    cfg_chg = 1'b1;
    @(negedge CLKS);
    cfg_chg = 1'b0;
  endtask

  task automatic report_test(input int id, input string name);
    if (test_errs(id) == 0) begin
      $display("test %0d (%s): passed", id, name);
      tests_passed++;
    end else begin
      $display("test %0d (%s): failed, %0d errors", id, name, test_errs(id));
    end
  endtask

  // the five tests in order, a timeout ends the sequence early.
  task automatic run_tests();
    logic [1:0] sel_a;
    int         n;
    take_snapshot();
    expect_bit("cfg_busy", cfg_busy, 1'b1, 1);
    expect_bit("pll_rst", pll_rst, 1'b1, 1);

    wait_busy(1'b0, 1000);
    if (timeouts > 0) begin
      return;
    end
    check_regs(2'd0, 1);
    check_fast_release();
    report_test(1, "initial load of set 0");

    for (int k = 0; k < 20; k++) begin
      take_snapshot();
      sel_a = 2'($urandom % 4);
      pulse_chg(sel_a);
      expect_bit("cfg_busy", cfg_busy, 1'b1, 2);
      expect_bit("pll_rst", pll_rst, 1'b1, 2);
      wait_busy(1'b0, 1000);
      if (timeouts > 0) begin
        return;
      end
      check_regs(sel_a, 2);
      check_fast_release();
    end
    report_test(2, "random reconfiguration");

    // a second strobe lands in the middle of the DRP accesses.
    take_snapshot();
    sel_a = 2'($urandom % 4);
    pulse_chg(sel_a);
    repeat (1 + ($urandom % 8)) @(negedge CLKS);
    expect_bit("cfg_busy", cfg_busy, 1'b1, 3);
    pulse_chg(sel_a + 2'd1);
    wait_busy(1'b0, 1000);
    if (timeouts > 0) begin
      return;
    end
    check_regs(sel_a, 3);
    check_fast_release();
    for (n = 0; n < 8; n++) begin
      @(negedge CLKS);
      expect_bit("cfg_busy", cfg_busy, 1'b0, 3);
    end
    report_test(3, "strobe while busy");

    n = 0;
    while (!rst_out.rstx_slow && n < 80) begin
      @(negedge CLKS);
      n++;
    end
    if (!rst_out.rstx_slow) begin
      give_up("rise of rstx_slow");
      return;
    end
    report_test(4, "reset release order");

    n = ticks_seen + 4;
    while (ticks_seen < n && tick_gap < 200) begin
      @(negedge CLKS);
    end
    if (ticks_seen < n) begin
      give_up("slow_tick pulse");
      return;
    end
    report_test(5, "clock divider");
  endtask

  // DRP register file and lock output of the PLL.
  always @(negedge CLKS) begin
    if (!filled) begin
      for (int a = 0; a < 32; a++) begin
        regfile[a[4:0]] = 16'($urandom);
      end
      filled = 1'b1;
    end
    if (drp_req.den && port_busy) begin
      $display("den at %0t came before drp_rdy of the previous access", $time);
      port_errs++;
    end
    drp_rdy <= 1'b0;
    if (rdy_cnt > 0) begin
      rdy_cnt--;
      if (rdy_cnt == 0) begin
        drp_rdy   <= 1'b1;
        port_busy = 1'b0;
        if (pend.dwe) begin
          regfile[pend.daddr] = pend.di;
        end else begin
          drp_do <= regfile[pend.daddr];
        end
      end
    end
    if (drp_req.den) begin
      if (pll_rst !== 1'b1) begin
        $display("CHECK FAILED at %0t: pll_rst got %b expected 1", $time, pll_rst);
        den_errs++;
      end
      if (drp_req.dwe) begin
        if (!rd_valid || rd_addr !== drp_req.daddr) begin
          $display("write to %02h at %0t had no read of that address", drp_req.daddr, $time);
          port_errs++;
        end
        rd_valid = 1'b0;
      end else begin
        rd_valid = 1'b1;
        rd_addr  = drp_req.daddr;
      end
      pend      = drp_req;
      port_busy = 1'b1;
      rdy_cnt   = 1 + int'($urandom % 4);
    end
    if (pll_rst) begin
      pll_locked <= 1'b0;
      lock_cnt   = 5 + int'($urandom % 16);
    end else if (lock_cnt > 0) begin
      lock_cnt--;
      if (lock_cnt == 0) begin
        pll_locked <= 1'b1;
      end
    end
  end

  always @(negedge CLKS) begin
    // both domains drop one cycle after busy rises.
    if (busy_d && cfg_busy && (rst_out.rstx_fast || rst_out.rstx_slow)) begin
      $display("CHECK FAILED at %0t: rst_out got %b expected 00", $time, rst_out);
      rel_errs++;
    end
    if (rst_out.rstx_slow && (!rst_out.rstx_fast || (!slow_d && !tick_d))) begin
      $display("CHECK FAILED at %0t: rstx_slow got 1 expected 0", $time);
      rel_errs++;
    end
    busy_d = cfg_busy;
    slow_d = rst_out.rstx_slow;
    tick_d = slow_tick;
  end

  always @(negedge CLKS) begin
    if (slow_tick !== (clkf_data && !clkf_d)) begin
      $display("CHECK FAILED at %0t: slow_tick got %b expected %b",
               $time, slow_tick, clkf_data && !clkf_d);
      div_errs++;
    end
    if (clkf_data !== clkf_d) begin
      if (runs_seen > 0 && run_len != 16) begin
        $display("CHECK FAILED at %0t: clkf_data run got %0d expected 16", $time, run_len);
        div_errs++;
      end
      runs_seen++;
      run_len = 1;
    end else begin
      run_len++;
    end
    tick_gap++;
    if (slow_tick) begin
      if (ticks_seen > 0 && tick_gap != 32) begin
        $display("CHECK FAILED at %0t: slow_tick period got %0d expected 32", $time, tick_gap);
        div_errs++;
      end
      tick_gap = 0;
      ticks_seen++;
    end
    clkf_d = clkf_data;
  end

  initial begin
    int total;
    void'($urandom(32'hf047_a51e));
    RSTXS   = 1'b0;
    cfg_sel = '0;
    cfg_chg = 1'b0;
    repeat (5) @(negedge CLKS);
    RSTXS = 1'b1;
    run_tests();

    total = timeouts;
    for (int id = 1; id <= 5; id++) begin
      total += test_errs(id);
    end
    $display("tests 5, passed %0d, failed %0d, errors %0d",
             tests_passed, 5 - tests_passed, total);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
